// File: eeprom_pkg.sv
package eeprom_pkg;

    // 24C16 geometry
    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    // four quarters per scl bit cell
    localparam int QTR_DIV = 4;
    localparam int QCNT_W  = $clog2(QTR_DIV);

    // bit index of the acknowledge slot in a byte cell
    localparam logic [3:0] LAST_BIT = 4'd8;

    // control byte is {DEV_CODE, addr[10:8], dir}
    localparam logic [3:0] DEV_CODE  = 4'b1010;
    localparam logic       DIR_WRITE = 1'b0;
    localparam logic       DIR_READ  = 1'b1;

    // sequencer step counter and the stop step of each request type
    localparam int          STEP_W  = 3;
    localparam logic [2:0]  WR_LAST = 3'd4;
    localparam logic [2:0]  RD_LAST = 3'd6;

    typedef enum logic [1:0] {
        CMD_START = 2'd0, // repeated start when the bus is busy
        CMD_STOP  = 2'd1,
        CMD_WRITE = 2'd2,
        CMD_READ  = 2'd3
    } bit_cmd_t;

endpackage

// File: i2c_bit_if.sv
`timescale 1ns/1ps

interface i2c_bit_if;
    import eeprom_pkg::*;

    // sequencer side
    logic              cmd_valid;
    bit_cmd_t          cmd;
    logic [DATA_W-1:0] tx_byte;
    logic              rx_nack;   // drive no-ack on the ninth bit of a read

    // engine side
    logic              cmd_ready;
    logic              done;      // one-cycle pulse at command end
    logic [DATA_W-1:0] rx_byte;
    logic              ack_seen;

    modport seq (
        output cmd_valid, cmd, tx_byte, rx_nack,
        input  cmd_ready, done, rx_byte, ack_seen
    );

    modport eng (
        input  cmd_valid, cmd, tx_byte, rx_nack,
        output cmd_ready, done, rx_byte, ack_seen
    );

endinterface

// File: i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine (
    input  logic   CLK,
    input  logic   RESET,
    i2c_bit_if.eng bus,
    output logic   scl,
    output logic   sda_oe,
    input  logic   sda_in
);
    import eeprom_pkg::*;

    logic              busy;
    bit_cmd_t          cur_cmd;
    logic [QCNT_W-1:0] qcnt;
    logic [1:0]        qtr;       // quarter inside the bit cell
    logic [3:0]        bit_idx;
    logic [DATA_W-1:0] shreg;
    logic              nack_q;
    logic              accept;
    logic              tick;
    logic              last_bit;

    // sda pull-low for the first (scl low) quarter of a bit cell
    function automatic logic q0_oe(
        input bit_cmd_t   c,
        input logic [3:0] idx,
        input logic       msb,
        input logic       nack
    );
        case (c)
            CMD_START: q0_oe = 1'b0;  // release first, needed for repeated start
            CMD_STOP:  q0_oe = 1'b1;
            CMD_WRITE: q0_oe = (idx == LAST_BIT) ? 1'b0 : ~msb;
            default:   q0_oe = (idx == LAST_BIT) ? ~nack : 1'b0;
        endcase
    endfunction

    assign bus.cmd_ready = ~busy;
    assign accept        = bus.cmd_valid & ~busy;
    assign tick          = busy && (qcnt == QCNT_W'(QTR_DIV - 1));
    assign last_bit      = (cur_cmd == CMD_START) || (cur_cmd == CMD_STOP) ||
                           (bit_idx == LAST_BIT);
    assign bus.rx_byte   = shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy     <= 1'b0;
            cur_cmd  <= CMD_STOP;
            qcnt     <= '0;
            qtr      <= 2'd0;
            bit_idx  <= 4'd0;
            bus.done <= 1'b0;
            scl      <= 1'b1; // bus released
            sda_oe   <= 1'b0;
        end
        else
        begin
            bus.done <= 1'b0;
            if (accept)
            begin
                busy    <= 1'b1;
                cur_cmd <= bus.cmd;
                qcnt    <= '0;
                qtr     <= 2'd0;
                bit_idx <= 4'd0;
                sda_oe  <= q0_oe(bus.cmd, 4'd0, bus.tx_byte[DATA_W-1], bus.rx_nack);
                if (bus.cmd != CMD_START)
                    scl <= 1'b0;
            end
            else if (busy)
            begin
                qcnt <= qcnt + 1'b1;
                if (tick)
                begin
                    qcnt <= '0;
                    qtr  <= qtr + 2'd1;
                    case (qtr)
                        2'd0: scl <= 1'b1;
                        2'd1:
                        begin
                            // edges on sda while scl high
                            if (cur_cmd == CMD_START)
                                sda_oe <= 1'b1;
                            else if (cur_cmd == CMD_STOP)
                                sda_oe <= 1'b0;
                        end
                        2'd2:
                        begin
                            if (cur_cmd != CMD_STOP)
                                scl <= 1'b0;
                        end
                        default:
                        begin
                            if (last_bit)
                            begin
                                busy     <= 1'b0;
                                bus.done <= 1'b1;
                            end
                            else
                            begin
                                bit_idx <= bit_idx + 4'd1;
                                sda_oe  <= q0_oe(cur_cmd, bit_idx + 4'd1,
                                                 shreg[DATA_W-2], nack_q);
                            end
                        end
                    endcase
                end
            end
        end
    end

    // shift register and acknowledge capture
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            shreg  <= bus.tx_byte;
            nack_q <= bus.rx_nack;
        end
        else if (tick)
        begin
            if (qtr == 2'd1)
            begin
                // middle of scl high
                if (cur_cmd == CMD_READ && bit_idx != LAST_BIT)
                    shreg <= {shreg[DATA_W-2:0], sda_in};
                if (cur_cmd == CMD_WRITE && bit_idx == LAST_BIT)
                    bus.ack_seen <= ~sda_in;
            end
            else if (qtr == 2'd3 && cur_cmd == CMD_WRITE && !last_bit)
            begin
                shreg <= shreg << 1;
            end
        end
    end

endmodule

// File: eeprom_txn_seq.sv
`timescale 1ns/1ps

module eeprom_txn_seq (
    input  logic                         CLK,
    input  logic                         RESET,
    input  logic                         req_valid,
    output logic                         req_ready,
    input  logic                         req_write,
    input  logic [eeprom_pkg::ADDR_W-1:0] req_addr,
    input  logic [eeprom_pkg::DATA_W-1:0] req_wdata,
    output logic                         rsp_valid,
    input  logic                         rsp_ready,
    output logic [eeprom_pkg::DATA_W-1:0] rsp_rdata,
    output logic                         rsp_nack,
    i2c_bit_if.seq                       bus
);
    import eeprom_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_CMD,
        S_WAIT,
        S_RESP
    } state_t;

    state_t            state;
    logic [STEP_W-1:0] step;
    logic [STEP_W-1:0] last_step;
    logic              nack_q;
    logic              wr_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [DATA_W-1:0] rdata_q;
    bit_cmd_t          step_cmd;
    logic [DATA_W-1:0] step_tx;

    assign last_step = wr_q ? WR_LAST : RD_LAST; // stop is always the last step

    // command list per request type
    always_comb
    begin
        step_cmd = CMD_WRITE;
        step_tx  = '0;
        case (step)
            3'd0: step_cmd = CMD_START;
            3'd1: step_tx  = {DEV_CODE, addr_q[ADDR_W-1:DATA_W], DIR_WRITE};
            3'd2: step_tx  = addr_q[DATA_W-1:0];
            3'd3:
            begin
                if (wr_q)
                    step_tx = wdata_q;
                else
                    step_cmd = CMD_START; // repeated start
            end
            3'd4:
            begin
                if (wr_q)
                    step_cmd = CMD_STOP;
                else
                    step_tx = {DEV_CODE, addr_q[ADDR_W-1:DATA_W], DIR_READ};
            end
            3'd5: step_cmd = CMD_READ;
            default: step_cmd = CMD_STOP;
        endcase
    end

    assign bus.cmd_valid = (state == S_CMD);
    assign bus.cmd       = step_cmd;
    assign bus.tx_byte   = step_tx;
    assign bus.rx_nack   = 1'b1;  // single-byte read, always no-ack

    assign req_ready = (state == S_IDLE);
    assign rsp_valid = (state == S_RESP);
    assign rsp_rdata = rdata_q;
    assign rsp_nack  = nack_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= S_IDLE;
            step   <= '0;
            nack_q <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (req_valid)
                    begin
                        step   <= '0;
                        nack_q <= 1'b0;
                        state  <= S_CMD;
                    end
                end
                S_CMD:
                begin
                    if (bus.cmd_ready)
                        state <= S_WAIT;
                end
                S_WAIT:
                begin
                    if (bus.done)
                    begin
                        if (step_cmd == CMD_WRITE && !bus.ack_seen)
                        begin
                            nack_q <= 1'b1;      // abort with a stop
                            step   <= last_step;
                            state  <= S_CMD;
                        end
                        else if (step == last_step)
                        begin
                            state <= S_RESP;
                        end
                        else
                        begin
                            step  <= step + 1'b1;
                            state <= S_CMD;
                        end
                    end
                end
                default:
                begin
                    if (rsp_ready)
                        state <= S_IDLE;
                end
            endcase
        end
    end

    // request capture and read data
    always_ff @(posedge CLK)
    begin
        if (req_valid && req_ready)
        begin
            wr_q    <= req_write;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
            rdata_q <= '0;  // writes and aborted reads return zero
        end
        else if (state == S_WAIT && bus.done && step_cmd == CMD_READ)
        begin
            rdata_q <= bus.rx_byte;
        end
    end

endmodule

// File: eeprom_ctrl_top.sv
`timescale 1ns/1ps

module eeprom_ctrl_top (
    input  logic                         CLK,
    input  logic                         RESET,
    input  logic                         req_valid,
    output logic                         req_ready,
    input  logic                         req_write,
    input  logic [eeprom_pkg::ADDR_W-1:0] req_addr,
    input  logic [eeprom_pkg::DATA_W-1:0] req_wdata,
    output logic                         rsp_valid,
    input  logic                         rsp_ready,
    output logic [eeprom_pkg::DATA_W-1:0] rsp_rdata,
    output logic                         rsp_nack,
    output logic                         scl,
    output logic                         sda_oe,   // high pulls sda low
    input  logic                         sda_in
);

    i2c_bit_if u_bit_if ();

    eeprom_txn_seq u_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .rsp_nack  (rsp_nack),
        .bus       (u_bit_if.seq)
    );

    i2c_bit_engine u_eng (
        .CLK    (CLK),
        .RESET  (RESET),
        .bus    (u_bit_if.eng),
        .scl    (scl),
        .sda_oe (sda_oe),
        .sda_in (sda_in)
    );

endmodule

// File: eeprom_slave_model.sv
`timescale 1ns/1ps

module eeprom_slave_model (
    input  logic scl,
    input  logic sda,       // resolved line
    input  logic enable,    // low means no acknowledge at all
    output logic sda_pull
);
    import eeprom_pkg::*;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_CTRL,
        PH_ADDR,
        PH_WDATA,
        PH_READ
    } phase_t;

    logic [DATA_W-1:0] mem [0:(1 << ADDR_W)-1];
    phase_t            phase = PH_IDLE;
    phase_t            next_phase = PH_IDLE;
    logic [3:0]        bcnt = 4'd0;   // scl rising edges seen in this byte cell
    logic [DATA_W-1:0] sh = '0;
    logic [ADDR_W-1:0] addr = '0;
    logic [DATA_W-1:0] rbyte = '0;

    initial
    begin
        sda_pull = 1'b0;
        for (int i = 0; i < (1 << ADDR_W); i++)
            mem[i] = 8'hff; // erased
    end

    // decide the acknowledge once eight bits are in
    task automatic end_of_byte;
        logic ack;
        ack        = 1'b0;
        next_phase = PH_IDLE;
        case (phase)
            PH_CTRL:
            begin
                if (enable && sh[DATA_W-1:DATA_W-4] == DEV_CODE)
                begin
                    ack  = 1'b1;
                    addr = {sh[3:1], addr[DATA_W-1:0]};
                    if (sh[0])
                    begin
                        next_phase = PH_READ;
                        rbyte      = mem[addr];
                    end
                    else
                        next_phase = PH_ADDR;
                end
            end
            PH_ADDR:
            begin
                ack        = enable;
                addr       = {addr[ADDR_W-1:DATA_W], sh};
                next_phase = enable ? PH_WDATA : PH_IDLE;
            end
            PH_WDATA:
            begin
                ack = enable;
                if (enable)
                    mem[addr] = sh;
            end
            default:
                ack = 1'b0;     // host drives the ninth bit on a read
        endcase
        sda_pull = ack;
    endtask

    // start and stop, sda moving while scl high
    always @(sda)
    begin
        if (scl === 1'b1 && sda !== 1'bx)
        begin
            phase    = (sda === 1'b0) ? PH_CTRL : PH_IDLE;
            bcnt     = 4'd0;
            sda_pull = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (phase != PH_IDLE)
        begin
            if (bcnt < 4'd8)
            begin
                sh   = {sh[DATA_W-2:0], sda};
                bcnt = bcnt + 4'd1;
            end
            else
                bcnt = 4'd9;    // acknowledge slot
        end
    end

    always @(negedge scl)
    begin
        if (phase != PH_IDLE)
        begin
            if (bcnt == 4'd8)
                end_of_byte();
            else if (bcnt == 4'd9)
            begin
                bcnt     = 4'd0;
                sda_pull = 1'b0;
                phase    = next_phase;
                if (phase == PH_READ)
                    sda_pull = ~rbyte[DATA_W-1];
            end
            else if (phase == PH_READ && bcnt != 4'd0)
                sda_pull = ~rbyte[DATA_W-1-bcnt];   // msb first
        end
    end

endmodule

// File: eeprom_ctrl_props.sv
`timescale 1ns/1ps

module eeprom_ctrl_props (
    input logic                          CLK,
    input logic                          RESET,
    input logic                          req_ready,
    input logic                          rsp_valid,
    input logic                          rsp_ready,
    input logic [eeprom_pkg::DATA_W-1:0] rsp_rdata,
    input logic                          rsp_nack,
    input logic                          scl,
    input logic                          sda_oe
);

    int assert_fails = 0;   // failed assertion count

    // stalled response stays put
    a_rsp_hold: assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata) && $stable(rsp_nack))
        else
        begin
            $error("response dropped or changed before rsp_ready");
            assert_fails++;
        end

    a_one_in_flight: assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid |-> !req_ready)
        else
        begin
            $error("req_ready high while a response is pending");
            assert_fails++;
        end

    a_bus_released: assert property (@(posedge CLK) RESET |=> scl && !sda_oe)
        else
        begin
            $error("bus not released after reset");
            assert_fails++;
        end

endmodule

bind eeprom_ctrl_top eeprom_ctrl_props u_props (
    .CLK       (CLK),
    .RESET     (RESET),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_rdata (rsp_rdata),
    .rsp_nack  (rsp_nack),
    .scl       (scl),
    .sda_oe    (sda_oe)
);

// File: tb_eeprom_ctrl.sv
`timescale 1ns/1ps

module tb_eeprom_ctrl;
    import eeprom_pkg::*;

    localparam int NUM_VEC  = 11;
    localparam int WDOG_CYC = NUM_VEC * 1200;

    logic              CLK;
    logic              RESET;
    logic              req_valid;
    logic              req_ready;
    logic              req_write;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic              rsp_valid;
    logic              rsp_ready;
    logic [DATA_W-1:0] rsp_rdata;
    logic              rsp_nack;
    logic              scl;
    logic              sda_oe;
    logic              sda_line;
    logic              model_pull;
    logic              model_en;

    logic [39:0] vectors [0:NUM_VEC-1];
    int          pending[$];    // accepted vector indices, oldest first
    int          rsp_count = 0;
    int          err_count = 0;
    int          fail_count = 0;
    logic [31:0] lfsr = 32'hf5c3_7580;

    assign sda_line = ~(sda_oe | model_pull);   // wired-and

    eeprom_ctrl_top u_dut (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .rsp_nack  (rsp_nack),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda_line)
    );

    eeprom_slave_model u_model (
        .scl      (scl),
        .sda      (sda_line),
        .enable   (model_en),
        .sda_pull (model_pull)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic send_request(input int idx);
        logic [39:0] v;
        v = vectors[idx];
        @(posedge CLK);
        req_valid <= 1'b1;
        req_write <= v[36];
        req_addr  <= v[34:24];
        req_wdata <= v[23:16];
        do
            @(posedge CLK);
        while (!req_ready);
        // bus is idle at acceptance, safe to switch the model
        model_en  <= v[0];
        req_valid <= 1'b0;
        pending.push_back(idx);
    endtask

    task automatic check_response;
        int          idx;
        int          errs;
        logic [39:0] v;
        errs = 0;
        rsp_count++;
        if (pending.size() == 0)
        begin
            $display("** Error: at time %0t, a response arrived with no request outstanding",
                     $time);
            err_count++;
            fail_count++;
        end
        else
        begin
            idx = pending.pop_front();
            v   = vectors[idx];
            if (rsp_rdata !== v[15:8])
            begin
                $display("** Error: at time %0t, rsp_rdata = %h, expected %h",
                         $time, rsp_rdata, v[15:8]);
                errs++;
            end
            if (rsp_nack !== v[4])
            begin
                $display("** Error: at time %0t, rsp_nack = %b, expected %b",
                         $time, rsp_nack, v[4]);
                errs++;
            end
            err_count += errs;
            if (errs != 0)
                fail_count++;
            $display("vector %0d: %s addr %h model %b -> rdata %h nack %b, %s", idx,
                     v[36] ? "write" : "read ", v[34:24], v[0], rsp_rdata, rsp_nack,
                     (errs == 0) ? "ok" : "wrong");
        end
    endtask

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // random host back-pressure
    always @(posedge CLK)
    begin
        lfsr = lfsr_step(lfsr);
        rsp_ready <= lfsr[0];
    end

    always @(posedge CLK)
    begin
        if (!RESET && rsp_valid && rsp_ready)
            check_response();
    end

    initial
    begin
        RESET     = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        rsp_ready = 1'b0;
        model_en  = 1'b1;
        $readmemh("eeprom_vectors.txt", vectors);
        repeat (3) @(posedge CLK);
        RESET <= 1'b0;
        for (int i = 0; i < NUM_VEC; i++)
            send_request(i);
        wait (rsp_count == NUM_VEC);
        repeat (100) @(posedge CLK);   // window for a duplicate response
        $display("%0d vectors, %0d responses, %0d failed, %0d errors, %0d assertion failures",
                 NUM_VEC, rsp_count, fail_count, err_count, u_dut.u_props.assert_fails);
        if (err_count == 0 && rsp_count == NUM_VEC && u_dut.u_props.assert_fails == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        repeat (WDOG_CYC) @(posedge CLK);
        $display("watchdog expired after %0d cycles with %0d of %0d responses",
                 WDOG_CYC, rsp_count, NUM_VEC);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: eeprom_ctrl_top.f
eeprom_pkg.sv
i2c_bit_if.sv
i2c_bit_engine.sv
eeprom_txn_seq.sv
eeprom_ctrl_top.sv
eeprom_slave_model.sv
eeprom_ctrl_props.sv
tb_eeprom_ctrl.sv

// File: eeprom_vectors.txt
// columns: op (1 write, 0 read), addr, wdata, expected rdata, expected nack, model on
// packed as o_aaa_ww_rr_n_m, all hex
1_123_5a_00_0_1
0_123_00_5a_0_1
1_723_c3_00_0_1
0_123_00_5a_0_1
0_723_00_c3_0_1
0_4f0_00_ff_0_1
1_123_99_00_1_0
0_123_00_00_1_0
0_123_00_5a_0_1
1_0ff_01_00_0_1
0_0ff_00_01_0_1
